//--- Bender.yml
package:
  name: board_top

sources:
  - logic/board_pkg.sv
  - logic/audio_pkg.sv
  - logic/slow_tick_gen.sv
  - logic/lcd_timing.sv
  - logic/lab_top.sv
  - logic/i2s_audio_out.sv
  - logic/board_top.sv
  - target: simulation
    files:
      - sim/tb_clock.sv
      - sim/tb_board_top.sv

//--- logic/audio_pkg.sv
package audio_pkg;

    // ------------------------------
    // Sample format
    // ------------------------------

    localparam int W_SAMPLE = 16;                 // Per channel, two's complement

    // ------------------------------
    // Serial timing
    // ------------------------------

    // clk cycles per half period of the bit clock
    localparam int BCK_DIV  = 4;

    // ------------------------------
    // Tone generator
    // ------------------------------

    // Amplitude per unit of sw, 15 x 2048 still fits a signed word
    localparam int AMP_STEP = 2048;

    typedef logic signed [W_SAMPLE - 1:0] sample_t;

endpackage

//--- logic/board_pkg.sv
package board_pkg;

    // ------------------------------
    // Screen geometry
    // ------------------------------

    localparam int SCREEN_W = 800;                // Visible pixels per line
    localparam int SCREEN_H = 480;                // Visible lines per frame

    // Horizontal timing in pixel clocks
    localparam int H_FRONT  = 40;
    localparam int H_SYNC   = 48;
    localparam int H_BACK   = 168;
    localparam int H_TOTAL  = SCREEN_W + H_FRONT + H_SYNC + H_BACK;  // 1056

    // Vertical timing in lines
    localparam int V_FRONT  = 13;
    localparam int V_SYNC   = 3;
    localparam int V_BACK   = 29;
    localparam int V_TOTAL  = SCREEN_H + V_FRONT + V_SYNC + V_BACK;  // 525

    // ------------------------------
    // Board I/O
    // ------------------------------

    localparam int TICK_DIV_DEFAULT = 27000000;   // One tick per second at 27 MHz

    localparam int W_KEY = 4;
    localparam int W_SW  = 4;
    localparam int W_LED = 6;

    typedef logic [$clog2(SCREEN_W) - 1:0] coord_x_t;  // 0..799
    typedef logic [$clog2(SCREEN_H) - 1:0] coord_y_t;  // 0..479
    typedef logic [$clog2(H_TOTAL)  - 1:0] h_cnt_t;    // Whole line incl. blanking
    typedef logic [$clog2(V_TOTAL)  - 1:0] v_cnt_t;    // Whole frame incl. blanking

    typedef logic [4:0]         red_t;            // RGB565 panel
    typedef logic [5:0]         green_t;
    typedef logic [4:0]         blue_t;
    typedef logic [W_LED - 1:0] led_t;

    typedef struct packed {
        logic     de;                             // Visible pixel
        logic     hs;                             // Active low
        logic     vs;                             // Active low
        coord_x_t x;
        coord_y_t y;
    } lcd_sync_t;

    typedef struct packed {
        red_t   r;
        green_t g;
        blue_t  b;
    } rgb_t;

endpackage

//--- logic/board_top.sv
module board_top
#(
    parameter int tick_div = board_pkg::TICK_DIV_DEFAULT
)
(
    input  logic                           clk,      // Also the pixel clock
    input  logic                           rst_n,

    input  logic [board_pkg::W_KEY - 1:0]  key,
    input  logic [board_pkg::W_SW  - 1:0]  sw,

    output board_pkg::led_t                led,

    output logic                           lcd_de,
    output logic                           lcd_hs,
    output logic                           lcd_vs,
    output board_pkg::red_t                lcd_r,
    output board_pkg::green_t              lcd_g,
    output board_pkg::blue_t               lcd_b,

    output logic                           hp_bck,   // Headphone DAC
    output logic                           hp_ws,
    output logic                           hp_din
);

    import board_pkg::*;
    import audio_pkg::*;

    logic      tick;
    lcd_sync_t sync_raw;                          // From the timing generator
    lcd_sync_t sync_out;                          // Delayed to match colour
    rgb_t      rgb;
    sample_t   sample;

    // ------------------------------
    // Blocks
    // ------------------------------

    slow_tick_gen #(.tick_div (tick_div)) i_slow_tick_gen
    (
        .clk   (clk),
        .rst_n (rst_n),
        .tick  (tick)
    );

    lcd_timing i_lcd_timing (.clk (clk), .rst_n (rst_n), .sync (sync_raw));

    lab_top i_lab_top
    (
        .clk    (clk),
        .rst_n  (rst_n),
        .tick   (tick),
        .key    (key),
        .sw     (sw),
        .sync   (sync_raw),
        .sync_q (sync_out),
        .rgb    (rgb),
        .led    (led),
        .sample (sample)
    );

    i2s_audio_out i_audio_out
    (
        .clk    (clk),
        .rst_n  (rst_n),
        .sample (sample),
        .bck    (hp_bck),
        .ws     (hp_ws),
        .sdata  (hp_din)
    );

    // Panel pins
    assign lcd_de = sync_out.de;
    assign lcd_hs = sync_out.hs;
    assign lcd_vs = sync_out.vs;
    assign lcd_r  = rgb.r;
    assign lcd_g  = rgb.g;
    assign lcd_b  = rgb.b;

endmodule

//--- logic/i2s_audio_out.sv
module i2s_audio_out
(
    input  logic               clk,
    input  logic               rst_n,
    input  audio_pkg::sample_t sample,            // Held as a level
    output logic               bck,               // Bit clock
    output logic               ws,                // Low = left, high = right
    output logic               sdata
);

    import audio_pkg::*;

    logic [$clog2(BCK_DIV) - 1:0] div_cnt;        // clk cycles in half period
    logic                         half_done;
    logic                         bck_fall;       // bck about to go low

    logic [4:0]                   bit_cnt;        // Slot in 32-bit frame
    logic [4:0]                   bit_cnt_next;
    logic [2 * W_SAMPLE - 1:0]    shift_q;        // Left word above right word

    // ------------------------------
    // Bit clock divider
    // ------------------------------

    assign half_done = (div_cnt == BCK_DIV - 1);
    assign bck_fall  = half_done && bck;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            div_cnt <= '0;
            bck     <= 1'b0;                      // Idle low
        end
        else if (half_done)
        begin
            div_cnt <= '0;
            bck     <= !bck;
        end
        else
        begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // ------------------------------
    // Frame and serializer
    // ------------------------------

    assign bit_cnt_next = bit_cnt + 5'd1;

    // Everything moves on the falling bck edge so the DAC samples
    // on the rising one. Slot 0 still carries the last bit of the
    // previous right word, which gives the one-bit I2S delay.
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            bit_cnt <= '1;                        // First fall opens a frame
            ws      <= 1'b0;
            sdata   <= 1'b0;
            shift_q <= '0;
        end
        else if (bck_fall)
        begin
            bit_cnt <= bit_cnt_next;
            ws      <= bit_cnt_next[4];           // Upper half of frame is right
            sdata   <= shift_q[$left(shift_q)];   // MSB first
            if (bit_cnt_next == '0)
                shift_q <= {sample, sample};      // Same word on both channels
            else
                shift_q <= shift_q << 1;
        end
    end

    // ------------------------------
    // Checks
    // ------------------------------

    // Ties the frame register to the divider phase
    a_ws_on_fall : assert property (
        @(posedge clk) disable iff (!rst_n)
        $changed(ws) |-> $fell(bck)
    ) else $error("ws changed away from falling bck");

endmodule

//--- logic/lab_top.sv
module lab_top
(
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           tick,     // From slow_tick_gen

    input  logic [board_pkg::W_KEY - 1:0]  key,
    input  logic [board_pkg::W_SW  - 1:0]  sw,

    input  board_pkg::lcd_sync_t           sync,     // Raw timing
    output board_pkg::lcd_sync_t           sync_q,   // Aligned with rgb
    output board_pkg::rgb_t                rgb,

    output board_pkg::led_t                led,
    output audio_pkg::sample_t             sample
);

    import board_pkg::*;
    import audio_pkg::*;

    logic [2:0] bar;                              // Colour bar index
    rgb_t       rgb_d;
    logic       tone_neg;                         // Sign of the square wave
    sample_t    tone_mag;

    // ------------------------------
    // LED tick counter
    // ------------------------------

    // Wraps at 64 by width, key[0] wins over a tick
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            led <= '0;
        else if (key[0])
            led <= '0;                            // Synchronous clear
        else if (tick)
            led <= led + 1'b1;
    end

    // ------------------------------
    // Colour bars
    // ------------------------------

    // Eight bars of 128 pixels, sw permutes them
    assign bar = sync.x[$left(sync.x) -: 3] ^ sw[2:0];

    always_comb
    begin
        rgb_d = '0;                               // Black in blanking
        if (sync.de)
        begin
            rgb_d.r = bar[0] ? '1 : '0;
            rgb_d.g = bar[1] ? '1 : '0;
            rgb_d.b = bar[2] ? '1 : '0;
        end
    end

    // Colour and syncs leave together, one cycle after lcd_timing
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            rgb       <= '0;
            sync_q.de <= 1'b0;
            sync_q.hs <= 1'b1;
            sync_q.vs <= 1'b1;
            sync_q.x  <= '0;
            sync_q.y  <= '0;
        end
        else
        begin
            rgb    <= rgb_d;
            sync_q <= sync;
        end
    end

    // ------------------------------
    // Square-wave tone
    // ------------------------------

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            tone_neg <= 1'b0;                     // Positive half first
        else if (tick)
            tone_neg <= !tone_neg;
    end

    assign tone_mag = sample_t'(AMP_STEP * int'(sw));  // Volume from sw
    assign sample   = tone_neg ? -tone_mag : tone_mag;

    // Painter and sync register must agree on blanking
    a_black_blank : assert property (
        @(posedge clk) disable iff (!rst_n)
        !sync_q.de |-> (rgb == '0)
    ) else $error("colour outside de");

endmodule

//--- logic/lcd_timing.sv
module lcd_timing
(
    input  logic                  clk,
    input  logic                  rst_n,
    output board_pkg::lcd_sync_t  sync
);

    import board_pkg::*;

    h_cnt_t h_cnt;                                // Pixel position in line
    v_cnt_t v_cnt;                                // Line position in frame

    logic   h_last;                               // Last count of a line
    logic   v_last;                               // Last line of a frame
    logic   h_vis;
    logic   v_vis;
    logic   hs_act;
    logic   vs_act;

    // ------------------------------
    // Counters
    // ------------------------------

    assign h_last = (h_cnt == h_cnt_t'(H_TOTAL - 1));
    assign v_last = (v_cnt == v_cnt_t'(V_TOTAL - 1));

    // Horizontal wraps every line, vertical steps once per line
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            h_cnt <= '0;
            v_cnt <= '0;
        end
        else if (h_last)
        begin
            h_cnt <= '0;
            if (v_last)
                v_cnt <= '0;                      // New frame
            else
                v_cnt <= v_cnt + 1'b1;
        end
        else
        begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    // ------------------------------
    // Region decode
    // ------------------------------

    // Visible area comes first in both directions
    assign h_vis  = (h_cnt < SCREEN_W);
    assign v_vis  = (v_cnt < SCREEN_H);

    // Sync pulses sit right after the front porch
    assign hs_act = (h_cnt >= SCREEN_W + H_FRONT)
                 && (h_cnt <  SCREEN_W + H_FRONT + H_SYNC);
    assign vs_act = (v_cnt >= SCREEN_H + V_FRONT)
                 && (v_cnt <  SCREEN_H + V_FRONT + V_SYNC);

    // ------------------------------
    // Registered outputs
    // ------------------------------

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            sync.de <= 1'b0;
            sync.hs <= 1'b1;                      // Syncs idle high
            sync.vs <= 1'b1;
            sync.x  <= '0;
            sync.y  <= '0;
        end
        else
        begin
            sync.de <= h_vis && v_vis;
            sync.hs <= !hs_act;
            sync.vs <= !vs_act;
            sync.x  <= coord_x_t'(h_cnt);         // Only meaningful while de
            sync.y  <= coord_y_t'(v_cnt);
        end
    end

    // ------------------------------
    // Checks
    // ------------------------------

    a_h_range : assert property (
        @(posedge clk) disable iff (!rst_n)
        h_cnt < H_TOTAL
    ) else $error("horizontal count out of range");

    // Sync pulse must stay inside horizontal blanking
    a_de_hs : assert property (
        @(posedge clk) disable iff (!rst_n)
        sync.de |-> sync.hs
    ) else $error("de high during hsync");

endmodule

//--- logic/slow_tick_gen.sv
module slow_tick_gen
#(
    parameter int tick_div = board_pkg::TICK_DIV_DEFAULT   // clk cycles per tick
)
(
    input  logic clk,
    input  logic rst_n,
    output logic tick                             // One clk wide strobe
);

    // Wide enough to hold tick_div - 1
    typedef logic [$clog2(tick_div + 1) - 1:0] cnt_t;

    cnt_t cnt;                                    // Cycles left until next tick

    // ------------------------------
    // Down-counter with reload
    // ------------------------------

    // The counter starts at tick_div - 1, so the first tick comes
    // tick_div cycles after reset release
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            cnt  <= cnt_t'(tick_div - 1);
            tick <= 1'b0;
        end
        else
        begin
            tick <= (cnt == '0);                  // Registered strobe
            if (cnt == '0)
                cnt <= cnt_t'(tick_div - 1);      // Reload
            else
                cnt <= cnt - 1'b1;
        end
    end

    // ------------------------------
    // Checks
    // ------------------------------

    // A tick is a single-cycle strobe, never a level
    a_tick_single : assert property (
        @(posedge clk) disable iff (!rst_n)
        tick |=> !tick
    ) else $error("tick high on two consecutive cycles");

endmodule

//--- sim/tb_board_top.sv
module tb_board_top;

    timeunit 1ns;
    timeprecision 1ps;

    import board_pkg::*;
    import audio_pkg::*;

    localparam int TICK_DIV  = 50;                // Short tick period
    localparam int FRAME_CYC = H_TOTAL * V_TOTAL + H_TOTAL;   // Longest LCD wait
    localparam int I2S_FRAME = 64 * BCK_DIV;      // clk cycles per stereo frame
    localparam int SEL_DE    = 0;
    localparam int SEL_HS    = 1;
    localparam int SEL_VS    = 2;

    logic             clk;
    logic             rst_n;
    logic [W_KEY-1:0] key;
    logic [W_SW-1:0]  sw;
    led_t             led;
    logic             lcd_de;
    logic             lcd_hs;
    logic             lcd_vs;
    red_t             lcd_r;
    green_t           lcd_g;
    blue_t            lcd_b;
    logic             hp_bck;
    logic             hp_ws;
    logic             hp_din;

    int cyc;                                      // Rising edges since reset release
    int checks   = 0;
    int errors   = 0;
    int timeouts = 0;

    tb_clock clock0 (.clk (clk), .rst_n (rst_n));

    board_top #(.tick_div (TICK_DIV)) dut0
    (
        .clk (clk), .rst_n (rst_n), .key (key), .sw (sw), .led (led),
        .lcd_de (lcd_de), .lcd_hs (lcd_hs), .lcd_vs (lcd_vs),
        .lcd_r (lcd_r), .lcd_g (lcd_g), .lcd_b (lcd_b),
        .hp_bck (hp_bck), .hp_ws (hp_ws), .hp_din (hp_din)
    );

    always @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            cyc <= 0;
        else
            cyc <= cyc + 1;
    end

    // ------------------------------
    // Helpers
    // ------------------------------

    task automatic check(input string msg, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp)
        begin
            $display("** Error at %0d ns: %s, got %0h, expected %0h", $time, msg, got, exp);
            errors++;
        end
    endtask

    function automatic logic pick(input int sel);
        case (sel)
            SEL_DE:  return lcd_de;
            SEL_HS:  return lcd_hs;
            default: return lcd_vs;
        endcase
    endfunction

    // Cycles until the selected LCD pin reaches level
    task automatic wait_level(input int sel, input logic level, input int limit,
                              input string what, output int cycles);
        cycles = 0;
        while (pick(sel) !== level && cycles < limit)
        begin
            @(negedge clk);
            cycles++;
        end
        if (pick(sel) !== level)
        begin
            $display("Timeout: %s did not happen within %0d cycles", what, limit);
            timeouts++;
        end
    endtask

    task automatic wait_cycle(input int target);
        int n;
        int limit;
        n     = 0;
        limit = target - cyc + 4;
        while (cyc < target && n < limit)
        begin
            @(negedge clk);
            n++;
        end
        if (cyc < target)
        begin
            $display("Timeout: cycle %0d after reset was never reached", target);
            timeouts++;
        end
    endtask

    task automatic check_idle(input string when);
        check({when, ": led"}, led, 0);
        check({when, ": colour"}, {lcd_r, lcd_g, lcd_b}, 0);
        check({when, ": audio pins"}, {hp_bck, hp_ws, hp_din}, 3'b000);
        check({when, ": de, hs, vs"}, {lcd_de, lcd_hs, lcd_vs}, 3'b011);
    endtask

    // ------------------------------
    // Tests
    // ------------------------------

    task automatic test_reset();
        int n;
        n = 0;
        repeat (4) @(negedge clk);
        check_idle("in reset");
        while (!rst_n && n < 64)
        begin
            @(posedge clk);
            n++;
        end
        if (!rst_n)
        begin
            $display("Timeout: reset was never released");
            timeouts++;
        end
        @(negedge clk);
        check_idle("after reset");
    endtask

    task automatic test_led();
        int k;
        int rel;
        for (k = 0; k < 70; k++)                  // Past the wrap at 64
        begin
            wait_cycle(TICK_DIV / 2 + k * TICK_DIV);   // Middle of period k
            check("led count", led, k % 64);
        end
        key[0] = 1'b1;
        wait_cycle(cyc + 1);
        check("led cleared by key", led, 0);
        rel = (cyc / TICK_DIV + 2) * TICK_DIV + TICK_DIV / 2;
        wait_cycle(rel - TICK_DIV);
        check("led held by key over a tick", led, 0);
        wait_cycle(rel);
        check("led held by key", led, 0);
        key[0] = 1'b0;
        for (k = 1; k < 4; k++)
        begin
            wait_cycle(rel + k * TICK_DIV);
            check("led count after clear", led, k);
        end
    endtask

    task automatic test_frame();
        int   c;
        int   n;
        int   hs_falls;
        int   vs_low;
        int   vs_lines;
        logic hs_d;
        logic vs_d;
        logic done;
        wait_level(SEL_VS, 1'b1, FRAME_CYC, "vsync high", c);
        wait_level(SEL_VS, 1'b0, FRAME_CYC, "vsync start", c);
        hs_falls = 0;
        vs_low   = 1;                             // This cycle is already low
        vs_lines = 0;
        n        = 0;
        done     = 1'b0;
        while (!done && n < FRAME_CYC)
        begin
            hs_d = lcd_hs;
            vs_d = lcd_vs;
            @(negedge clk);
            n++;
            if (vs_d && !lcd_vs)
                done = 1'b1;                      // Next frame's vsync
            else
            begin
                if (hs_d && !lcd_hs)
                    hs_falls++;
                if (hs_d && !lcd_hs && !lcd_vs)
                    vs_lines++;
                if (!lcd_vs)
                    vs_low++;
            end
        end
        if (!done)
        begin
            $display("Timeout: second vsync did not come within %0d cycles", FRAME_CYC);
            timeouts++;
        end
        check("hsync pulses per frame", hs_falls, V_TOTAL);
        check("vsync low cycles", vs_low, V_SYNC * H_TOTAL);
        check("lines inside vsync", vs_lines, V_SYNC);
    endtask

    task automatic test_lines();
        int line;
        int c0;
        int c_de;
        int c_front;
        int c_sync;
        int c_rest;
        wait_level(SEL_DE, 1'b0, FRAME_CYC, "DE low", c0);
        for (line = 0; line < 2; line++)
        begin
            wait_level(SEL_DE, 1'b1, FRAME_CYC, "DE rise", c0);
            wait_level(SEL_DE, 1'b0, H_TOTAL, "DE fall", c_de);
            wait_level(SEL_HS, 1'b0, H_TOTAL, "hsync start", c_front);
            wait_level(SEL_HS, 1'b1, H_TOTAL, "hsync end", c_sync);
            wait_level(SEL_HS, 1'b0, H_TOTAL, "next hsync", c_rest);
            check("DE length", c_de, SCREEN_W);
            check("hsync after DE", c_front, H_FRONT);
            check("hsync width", c_sync, H_SYNC);
            check("hsync period", c_sync + c_rest, H_TOTAL);
        end
    endtask

    task automatic test_colour();
        int       i;
        int       px;
        int       n;
        int       c;
        coord_x_t xv;
        logic [2:0] bar;
        rgb_t     exp_px;
        for (i = 0; i < 3; i++)
        begin
            sw = 4'($urandom_range(15, 0));
            wait_level(SEL_DE, 1'b0, FRAME_CYC, "end of visible line", c);
            wait_level(SEL_DE, 1'b1, FRAME_CYC, "start of visible line", c);
            for (px = 0; px < SCREEN_W; px++)     // x rebuilt from DE count
            begin
                xv       = coord_x_t'(px);
                bar      = xv[9:7] ^ sw[2:0];
                exp_px.r = {5{bar[0]}};
                exp_px.g = {6{bar[1]}};
                exp_px.b = {5{bar[2]}};
                check("DE inside line", lcd_de, 1);
                check($sformatf("colour at x=%0d", px), {lcd_r, lcd_g, lcd_b}, exp_px);
                @(negedge clk);
            end
            n = 0;
            while (!lcd_de && n < FRAME_CYC)      // Blanking up to the next line
            begin
                check("black outside DE", {lcd_r, lcd_g, lcd_b}, 0);
                @(negedge clk);
                n++;
            end
            if (!lcd_de)
            begin
                $display("Timeout: DE stayed low for %0d cycles", FRAME_CYC);
                timeouts++;
            end
        end
    endtask

    task automatic test_i2s();
        int          rnd;
        int          n;
        int          f;
        int          nbits;
        int          fall_t;
        int          left_t;
        int          start_t;
        int          ticks;
        int          flips;
        logic        prev_bck;
        logic        prev_ws;
        logic        dws;                         // ws at the previous bck rise
        logic        cur_ch;
        logic        neg;
        logic        prev_neg;                    // Sign bit of the last decoded word
        logic        have_prev;
        logic [15:0] word;
        logic [15:0] left;
        logic [15:0] expv;
        for (rnd = 0; rnd < 2; rnd++)
        begin
            sw        = 4'($urandom_range(15, 1));
            start_t   = cyc;
            f         = 0;
            n         = 0;
            nbits     = 0;
            flips     = 0;
            fall_t    = -1;
            left_t    = -1;
            word      = '0;
            left      = '0;
            have_prev = 1'b0;
            prev_neg  = 1'b0;
            prev_bck  = hp_bck;
            prev_ws   = hp_ws;
            dws       = hp_ws;
            cur_ch    = hp_ws;
            while (f < 6 && n < 9 * I2S_FRAME)
            begin
                @(negedge clk);
                n++;
                if (prev_ws && !hp_ws)
                    fall_t = cyc;                 // New sample taken here
                if (!prev_bck && hp_bck)
                begin
                    // With the one-bit delay a bit belongs to the channel of the slot before
                    if (dws != cur_ch)
                    begin
                        if (nbits == W_SAMPLE && cur_ch == 1'b0)
                        begin
                            left   = word;
                            left_t = fall_t;
                        end
                        else if (nbits == W_SAMPLE && left_t > start_t)
                        begin
                            // Sign flips the cycle after each tick
                            ticks = (left_t - 2) / TICK_DIV;
                            neg   = (ticks % 2) == 1;
                            expv  = 16'(int'(sw) * AMP_STEP);
                            if (neg)
                                expv = -expv;
                            check("left word", left, expv);
                            check("right word", word, expv);
                            if (have_prev && left[W_SAMPLE - 1] != prev_neg)
                                flips++;          // Sign change seen on hp_din
                            prev_neg  = left[W_SAMPLE - 1];
                            have_prev = 1'b1;
                            left_t    = -1;
                            f++;
                        end
                        cur_ch = dws;
                        nbits  = 0;
                        word   = '0;
                    end
                    word = {word[14:0], hp_din};
                    nbits++;
                    dws  = hp_ws;
                end
                prev_bck = hp_bck;
                prev_ws  = hp_ws;
            end
            if (f < 6)
            begin
                $display("Timeout: only %0d audio frames decoded", f);
                timeouts++;
            end
            check("tone sign alternates between tick periods", flips != 0, 1);
        end
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------

    initial
    begin
        void'($urandom(32'h0196055e));
        key = '0;
        sw  = '0;
        test_reset();
        test_led();
        test_frame();
        test_lines();
        test_colour();
        test_i2s();
        $display("%0d checks, %0d errors, %0d timeouts", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

//--- sim/tb_clock.sv
module tb_clock
(
    output logic clk,
    output logic rst_n
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int HALF_PERIOD  = 5;              // 10 ns clock
    localparam int RESET_CYCLES = 16;

    initial
    begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = !clk;
    end

    initial
    begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;                             // Released on a falling edge
    end

endmodule

//--- sources.f
logic/board_pkg.sv
logic/audio_pkg.sv
logic/slow_tick_gen.sv
logic/lcd_timing.sv
logic/lab_top.sv
logic/i2s_audio_out.sv
logic/board_top.sv
sim/tb_clock.sv
sim/tb_board_top.sv
